// ==== hdl/c64_loader_top.sv ====
// Loader top level. Connects the PRG loader, CRT parser and RAM eraser to
// the memory slot arbiter. Host stream in, memory writes out.
`timescale 1ns/10ps
`default_nettype none

module c64_loader_top (
	input  wire                    clk_sys,
	input  wire                    RESET,
	input  wire                    ioctl_download_i,
	input  wire loader_pkg::byte_t ioctl_index_i,
	input  wire                    ioctl_wr_i,
	input  wire loader_pkg::addr_t ioctl_addr_i,
	input  wire loader_pkg::byte_t ioctl_data_i,
	input  wire                    io_cycle_i,
	input  wire                    erase_start_i,
	output logic                   ioctl_wait_o,
	output logic                   mem_ce_o,
	output logic                   mem_we_o,
	output loader_pkg::addr_t      mem_addr_o,
	output loader_pkg::byte_t      mem_data_o,
	output logic [15:0]            cart_id_o,
	output loader_pkg::byte_t      cart_exrom_o,
	output loader_pkg::byte_t      cart_game_o,
	output loader_pkg::byte_t      bank_type_o,
	output logic [15:0]            bank_num_o,
	output logic [15:0]            bank_laddr_o,
	output logic [15:0]            bank_size_o,
	output logic                   bank_wr_o,
	output logic                   cart_attached_o,
	output logic                   inject_done_o,
	output logic                   erase_busy_o
);

	// Peer request sets
	logic              prg_req, prg_gnt;
	loader_pkg::addr_t prg_addr;
	loader_pkg::byte_t prg_data;
	logic              crt_req, crt_gnt;
	loader_pkg::addr_t crt_addr;
	loader_pkg::byte_t crt_data;
	logic              erase_req, erase_gnt;
	loader_pkg::addr_t erase_addr;
	loader_pkg::byte_t erase_data;

	prg_loader u_prg (
		.clk_sys(clk_sys), .RESET(RESET), .ioctl_download_i(ioctl_download_i),
		.ioctl_index_i(ioctl_index_i), .ioctl_wr_i(ioctl_wr_i),
		.ioctl_addr_i(ioctl_addr_i), .ioctl_data_i(ioctl_data_i), .gnt_i(prg_gnt),
		.req_o(prg_req), .addr_o(prg_addr), .data_o(prg_data),
		.inject_done_o(inject_done_o)
	);

	crt_parser u_crt (
		.clk_sys(clk_sys), .RESET(RESET), .ioctl_download_i(ioctl_download_i),
		.ioctl_index_i(ioctl_index_i), .ioctl_wr_i(ioctl_wr_i),
		.ioctl_addr_i(ioctl_addr_i), .ioctl_data_i(ioctl_data_i), .gnt_i(crt_gnt),
		.req_o(crt_req), .addr_o(crt_addr), .data_o(crt_data),
		.cart_id_o(cart_id_o), .cart_exrom_o(cart_exrom_o), .cart_game_o(cart_game_o),
		.bank_type_o(bank_type_o), .bank_num_o(bank_num_o), .bank_laddr_o(bank_laddr_o),
		.bank_size_o(bank_size_o), .bank_wr_o(bank_wr_o), .cart_attached_o(cart_attached_o)
	);

	ram_eraser u_erase (
		.clk_sys(clk_sys), .RESET(RESET), .start_i(erase_start_i), .gnt_i(erase_gnt),
		.req_o(erase_req), .addr_o(erase_addr), .data_o(erase_data), .busy_o(erase_busy_o)
	);

	mem_slot_arbiter u_arb (
		.clk_sys(clk_sys), .RESET(RESET), .io_cycle_i(io_cycle_i),
		.erase_req_i(erase_req), .erase_addr_i(erase_addr), .erase_data_i(erase_data),
		.erase_gnt_o(erase_gnt),
		.prg_req_i(prg_req), .prg_addr_i(prg_addr), .prg_data_i(prg_data),
		.prg_gnt_o(prg_gnt),
		.crt_req_i(crt_req), .crt_addr_i(crt_addr), .crt_data_i(crt_data),
		.crt_gnt_o(crt_gnt),
		.mem_ce_o(mem_ce_o), .mem_we_o(mem_we_o), .mem_addr_o(mem_addr_o),
		.mem_data_o(mem_data_o), .wait_o(ioctl_wait_o)
	);

endmodule

`default_nettype wire

// ==== hdl/crt_parser.sv ====
// CRT cartridge file parser. Latches the file header fields, walks the chip
// packets and reports each bank header with a one clock strobe. Packet data
// is requested for writing from the cartridge base, 8 KB aligned per packet.
`timescale 1ns/10ps
`default_nettype none

module crt_parser (
	input  wire                    clk_sys,
	input  wire                    RESET,
	input  wire                    ioctl_download_i,
	input  wire loader_pkg::byte_t ioctl_index_i,
	input  wire                    ioctl_wr_i,
	input  wire loader_pkg::addr_t ioctl_addr_i,
	input  wire loader_pkg::byte_t ioctl_data_i,
	input  wire                    gnt_i,
	output logic                   req_o,
	output loader_pkg::addr_t      addr_o,
	output loader_pkg::byte_t      data_o,
	output logic [15:0]            cart_id_o,
	output loader_pkg::byte_t      cart_exrom_o,
	output loader_pkg::byte_t      cart_game_o,
	output loader_pkg::byte_t      bank_type_o,
	output logic [15:0]            bank_num_o,
	output logic [15:0]            bank_laddr_o,
	output logic [15:0]            bank_size_o,
	output logic                   bank_wr_o,
	output logic                   cart_attached_o
);

	localparam int AW = loader_pkg::ADDR_W;
	localparam int BW = loader_pkg::BANK_ALIGN_W;

	logic              load_crt;
	logic              old_download;
	logic [3:0]        hdr_cnt;
	logic [31:0]       blk_len;
	loader_pkg::addr_t wr_addr;

	assign load_crt = (ioctl_index_i == loader_pkg::IDX_CRT);

	always_ff @(posedge clk_sys) begin
		old_download <= ioctl_download_i;
		bank_wr_o    <= 1'b0;

		if (gnt_i)
			req_o <= 1'b0;

		if (ioctl_wr_i && ioctl_download_i && load_crt) begin
			if (ioctl_addr_i == loader_pkg::addr_t'(0)) begin
				wr_addr <= loader_pkg::CRT_BASE;
				blk_len <= '0;
				hdr_cnt <= '0;
			end

			// ========================================
			// File header, id is big endian
			// ========================================
			if (ioctl_addr_i == loader_pkg::addr_t'('h16)) cart_id_o[15:8] <= ioctl_data_i;
			if (ioctl_addr_i == loader_pkg::addr_t'('h17)) cart_id_o[7:0]  <= ioctl_data_i;
			if (ioctl_addr_i == loader_pkg::addr_t'('h18)) cart_exrom_o    <= ioctl_data_i;
			if (ioctl_addr_i == loader_pkg::addr_t'('h19)) cart_game_o     <= ioctl_data_i;

			// ========================================
			// Chip packets
			// ========================================
			if (ioctl_addr_i >= loader_pkg::CRT_HDR_START) begin
				if (blk_len == '0 && hdr_cnt == '0) begin
					// First byte of a packet header
					hdr_cnt <= 4'd1;
					if (wr_addr[BW-1:0] != '0) begin
						wr_addr[BW-1:0]    <= '0;
						wr_addr[AW-1:BW]   <= wr_addr[AW-1:BW] + 1'b1;
					end
				end else if (hdr_cnt != '0) begin
					// Wraps to zero after the last header byte
					hdr_cnt <= hdr_cnt + 1'b1;
					case (hdr_cnt)
						4'd4:  blk_len[31:24]     <= ioctl_data_i;
						4'd5:  blk_len[23:16]     <= ioctl_data_i;
						4'd6:  blk_len[15:8]      <= ioctl_data_i;
						4'd7:  blk_len[7:0]       <= ioctl_data_i;
						// Packet length includes its own header
						4'd8:  blk_len            <= blk_len - loader_pkg::CRT_PKT_HDR_LEN;
						4'd9:  bank_type_o        <= ioctl_data_i;
						4'd10: bank_num_o[15:8]   <= ioctl_data_i;
						4'd11: bank_num_o[7:0]    <= ioctl_data_i;
						4'd12: bank_laddr_o[15:8] <= ioctl_data_i;
						4'd13: bank_laddr_o[7:0]  <= ioctl_data_i;
						4'd14: bank_size_o[15:8]  <= ioctl_data_i;
						4'd15: begin
							bank_size_o[7:0] <= ioctl_data_i;
							bank_wr_o        <= 1'b1;
						end
						default: begin
							// Signature bytes are not checked
						end
					endcase
				end else begin
					blk_len <= blk_len - 1'b1;
					req_o   <= 1'b1;
					addr_o  <= wr_addr;
					data_o  <= ioctl_data_i;
					wr_addr <= wr_addr + 1'b1;
				end
			end
		end

		// Attached once the download ends, detached when a new one starts
		if (old_download != ioctl_download_i && load_crt)
			cart_attached_o <= old_download;

		if (RESET) begin
			req_o           <= 1'b0;
			bank_wr_o       <= 1'b0;
			cart_attached_o <= 1'b0;
			old_download    <= 1'b0;
			hdr_cnt         <= '0;
			blk_len         <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/loader_pkg.sv ====
// Shared widths, file indices and fixed addresses for the file loader.
// Modules refer to these by scoped names, loader_pkg::name.
`default_nettype none

package loader_pkg;

	// ========================================
	// Memory and data widths
	// ========================================
	localparam int ADDR_W = 25;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [7:0]        byte_t;

	// Host file indices
	localparam byte_t IDX_PRG = 8'd4;
	localparam byte_t IDX_CRT = 8'd5;

	// ========================================
	// Cartridge image layout
	// ========================================
	localparam addr_t CRT_BASE      = 25'h100000;
	// First chip packet follows the 64 byte file header
	localparam addr_t CRT_HDR_START = 25'h40;
	localparam logic [31:0] CRT_PKT_HDR_LEN = 32'd16;
	// Packet data starts on an 8 KB boundary
	localparam int BANK_ALIGN_W = 13;

	// Main RAM erase
	localparam logic [15:0] RAM_LAST     = 16'hFFFF;
	localparam int          ERASE_PACE_W = 5;

	// ========================================
	// BASIC pointer injection
	// ========================================
	// Zero page scan stops here
	localparam logic [8:0] INJ_LAST = 9'h100;
	// TXT pointer as left by reset
	localparam byte_t BASIC_TXT_LO = 8'h01;
	localparam byte_t BASIC_TXT_HI = 8'h08;

endpackage

`default_nettype wire

// ==== hdl/mem_slot_arbiter.sv ====
// Memory slot arbiter. Picks one pending peer request by fixed priority,
// eraser, then PRG, then CRT, and issues it as a write in the next free
// window of the computer core. wait_o holds the host stream back.
`timescale 1ns/10ps
`default_nettype none

module mem_slot_arbiter (
	input  wire                    clk_sys,
	input  wire                    RESET,
	input  wire                    io_cycle_i,
	input  wire                    erase_req_i,
	input  wire loader_pkg::addr_t erase_addr_i,
	input  wire loader_pkg::byte_t erase_data_i,
	output logic                   erase_gnt_o,
	input  wire                    prg_req_i,
	input  wire loader_pkg::addr_t prg_addr_i,
	input  wire loader_pkg::byte_t prg_data_i,
	output logic                   prg_gnt_o,
	input  wire                    crt_req_i,
	input  wire loader_pkg::addr_t crt_addr_i,
	input  wire loader_pkg::byte_t crt_data_i,
	output logic                   crt_gnt_o,
	output logic                   mem_ce_o,
	output logic                   mem_we_o,
	output loader_pkg::addr_t      mem_addr_o,
	output loader_pkg::byte_t      mem_data_o,
	output logic                   wait_o
);

	logic              io_cycle_d;
	logic              win_fall;
	logic              win_high;
	logic [2:0]        pick;
	loader_pkg::addr_t sel_addr;
	loader_pkg::byte_t sel_data;

	assign win_fall = ~io_cycle_i & io_cycle_d;
	assign win_high = io_cycle_i & io_cycle_d;

	// Host must pause while a stream byte is still waiting for memory
	assign wait_o = prg_req_i | crt_req_i;

	// ========================================
	// Fixed priority pick
	// ========================================
	always_comb begin
		pick     = 3'b000;
		sel_addr = crt_addr_i;
		sel_data = crt_data_i;
		if (erase_req_i) begin
			pick     = 3'b001;
			sel_addr = erase_addr_i;
			sel_data = erase_data_i;
		end else if (prg_req_i) begin
			pick     = 3'b010;
			sel_addr = prg_addr_i;
			sel_data = prg_data_i;
		end else if (crt_req_i) begin
			pick     = 3'b100;
		end
	end

	// ========================================
	// Window tracking and write issue
	// ========================================
	always_ff @(posedge clk_sys) begin
		io_cycle_d <= io_cycle_i;
		{crt_gnt_o, prg_gnt_o, erase_gnt_o} <= 3'b000;

		if (win_fall && pick != 3'b000) begin
			{crt_gnt_o, prg_gnt_o, erase_gnt_o} <= pick;
			mem_ce_o   <= 1'b1;
			mem_we_o   <= 1'b1;
			mem_addr_o <= sel_addr;
			mem_data_o <= sel_data;
		end

		// Window reopened, the write has been taken
		if (win_high) begin
			mem_ce_o <= 1'b0;
			mem_we_o <= 1'b0;
		end

		if (RESET) begin
			io_cycle_d <= 1'b0;
			mem_ce_o   <= 1'b0;
			mem_we_o   <= 1'b0;
			{crt_gnt_o, prg_gnt_o, erase_gnt_o} <= 3'b000;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/prg_loader.sv ====
// PRG file loader. Takes the load address from the first two bytes of the
// host stream and requests one memory write per following byte. After the
// download it walks the zero page and patches the BASIC pointers.
`timescale 1ns/10ps
`default_nettype none

module prg_loader (
	input  wire                    clk_sys,
	input  wire                    RESET,
	input  wire                    ioctl_download_i,
	input  wire loader_pkg::byte_t ioctl_index_i,
	input  wire                    ioctl_wr_i,
	input  wire loader_pkg::addr_t ioctl_addr_i,
	input  wire loader_pkg::byte_t ioctl_data_i,
	input  wire                    gnt_i,
	output logic                   req_o,
	output loader_pkg::addr_t      addr_o,
	output loader_pkg::byte_t      data_o,
	output logic                   inject_done_o
);

	logic              load_prg;
	logic              old_download;
	logic              inj_active;
	logic [8:0]        inj_addr;
	logic [15:0]       inj_end;
	loader_pkg::addr_t load_addr;

	assign load_prg = (ioctl_index_i == loader_pkg::IDX_PRG);

	always_ff @(posedge clk_sys) begin
		old_download  <= ioctl_download_i;
		inject_done_o <= 1'b0;

		// Request is held until the arbiter grants it
		if (gnt_i)
			req_o <= 1'b0;

		// ========================================
		// Header capture and data bytes
		// ========================================
		if (ioctl_wr_i && ioctl_download_i && load_prg) begin
			if (ioctl_addr_i == loader_pkg::addr_t'(0)) begin
				load_addr <= loader_pkg::addr_t'(ioctl_data_i);
				inj_end[7:0] <= ioctl_data_i;
			end else if (ioctl_addr_i == loader_pkg::addr_t'(1)) begin
				load_addr[15:8] <= ioctl_data_i;
				inj_end[15:8] <= ioctl_data_i;
			end else begin
				req_o     <= 1'b1;
				addr_o    <= load_addr;
				data_o    <= ioctl_data_i;
				load_addr <= load_addr + 1'b1;
				// End pointer follows the last byte written
				inj_end   <= inj_end + 1'b1;
			end
		end

		// ========================================
		// Zero page pointer injection
		// ========================================
		if (old_download && !ioctl_download_i && load_prg) begin
			inj_active <= 1'b1;
			inj_addr   <= '0;
		end else if (inj_active && !req_o) begin
			if (inj_addr == loader_pkg::INJ_LAST) begin
				inj_active    <= 1'b0;
				inject_done_o <= 1'b1;
			end else begin
				inj_addr <= inj_addr + 1'b1;
				addr_o   <= loader_pkg::addr_t'(inj_addr);
				case (inj_addr)
					// TXT start, same as after reset
					9'h02B: begin
						req_o  <= 1'b1;
						data_o <= loader_pkg::BASIC_TXT_LO;
					end
					9'h02C: begin
						req_o  <= 1'b1;
						data_o <= loader_pkg::BASIC_TXT_HI;
					end
					// SAVE start cleared
					9'h0AC, 9'h0AD: begin
						req_o  <= 1'b1;
						data_o <= 8'h00;
					end
					// VAR, ARY, STR and LOAD end all point past the program
					9'h02D, 9'h02F, 9'h031, 9'h0AE: begin
						req_o  <= 1'b1;
						data_o <= inj_end[7:0];
					end
					9'h02E, 9'h030, 9'h032, 9'h0AF: begin
						req_o  <= 1'b1;
						data_o <= inj_end[15:8];
					end
					default: begin
						// Other zero page bytes keep their contents
					end
				endcase
			end
		end

		if (RESET) begin
			req_o         <= 1'b0;
			inject_done_o <= 1'b0;
			inj_active    <= 1'b0;
			old_download  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/ram_eraser.sv ====
// Main RAM eraser. Fills the 64 KB RAM with the power-on stripe pattern,
// 0xFF where address bit 6 is set and 0x00 elsewhere, paced to one write
// request per 32 clocks at most.
`timescale 1ns/10ps
`default_nettype none

module ram_eraser (
	input  wire               clk_sys,
	input  wire               RESET,
	input  wire               start_i,
	input  wire               gnt_i,
	output logic              req_o,
	output loader_pkg::addr_t addr_o,
	output loader_pkg::byte_t data_o,
	output logic              busy_o
);

	logic [loader_pkg::ERASE_PACE_W-1:0] pace;
	logic [15:0]                         erase_addr;

	always_ff @(posedge clk_sys) begin
		if (start_i) begin
			busy_o     <= 1'b1;
			req_o      <= 1'b0;
			erase_addr <= '0;
			pace       <= '0;
		end else if (busy_o) begin
			if (gnt_i) begin
				req_o <= 1'b0;
				if (erase_addr == loader_pkg::RAM_LAST)
					busy_o <= 1'b0;
				else
					erase_addr <= erase_addr + 1'b1;
			end else if (!req_o) begin
				// Pacing runs only between requests
				pace <= pace + 1'b1;
				if (&pace) begin
					req_o  <= 1'b1;
					addr_o <= loader_pkg::addr_t'(erase_addr);
					data_o <= {8{erase_addr[6]}};
				end
			end
		end

		if (RESET) begin
			busy_o <= 1'b0;
			req_o  <= 1'b0;
			pace   <= '0;
		end
	end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the loader testbench with Verilator, run it, and look for the pass line
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_c64_loader -f sources.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
	exit 0
fi
echo "Simulation did not report a pass"
exit 1

// ==== sources.f ====
hdl/loader_pkg.sv
hdl/prg_loader.sv
hdl/crt_parser.sv
hdl/ram_eraser.sv
hdl/mem_slot_arbiter.sv
hdl/c64_loader_top.sv
+incdir+include
tb/tb_c64_loader.sv

// ==== include/tb_loader_model.svh ====
// Memory model, file builders and expected write lists for the loader testbench.
// Included inside the testbench module, after its seed and error counter.
`ifndef TB_LOADER_MODEL_SVH
`define TB_LOADER_MODEL_SVH

// Main RAM image as seen through the memory port
logic [7:0]  ram [0:65535];
// Writes seen on the memory port, and the writes the rules call for
int          log_addr [$];
logic [7:0]  log_data [$];
int          exp_addr [$];
logic [7:0]  exp_data [$];
logic [7:0]  file_buf [$];
// Set for each file byte that turns into a memory write
bit          file_wr [$];

logic [7:0]  exp_bank_type  [0:1];
logic [15:0] exp_bank_num   [0:1];
logic [15:0] exp_bank_laddr [0:1];
logic [15:0] exp_bank_size  [0:1];
logic [15:0] exp_cart_id;
logic [7:0]  exp_exrom;
logic [7:0]  exp_game;
logic [15:0] prg_end;

function automatic int rand_range(int lo, int hi);
	int r;
	r = $random(seed) & 32'h7fff_ffff;
	return lo + r % (hi - lo + 1);
endfunction

// Power-on stripe of 0xFF where address bit 6 is set
function automatic logic [7:0] stripe_byte(int a);
	return ((a & 64) != 0) ? 8'hFF : 8'h00;
endfunction

task automatic push_exp(int a, logic [7:0] d);
	exp_addr.push_back(a);
	exp_data.push_back(d);
endtask

task automatic push_file(logic [7:0] b, bit makes_write);
	file_buf.push_back(b);
	file_wr.push_back(makes_write);
endtask

task automatic clear_lists();
	file_buf.delete();
	file_wr.delete();
	exp_addr.delete();
	exp_data.delete();
endtask

task automatic expect_erase();
	clear_lists();
	for (int a = 0; a < 65536; a++)
		push_exp(a, stripe_byte(a));
endtask

// ========================================
// PRG file and zero page pointers
// ========================================
task automatic build_prg();
	int n;
	int load;
	logic [7:0] b;
	clear_lists();
	n = rand_range(20, 60);
	load = rand_range(32'h0801, 32'h9000);
	push_file(8'(load), 1'b0);
	push_file(8'(load >> 8), 1'b0);
	for (int i = 0; i < n; i++) begin
		b = 8'(rand_range(0, 255));
		push_file(b, 1'b1);
		push_exp(load + i, b);
	end
	prg_end = 16'(load + n);
	// Pointer writes come in zero page scan order
	push_exp(32'h2B, 8'h01);
	push_exp(32'h2C, 8'h08);
	push_exp(32'h2D, prg_end[7:0]);
	push_exp(32'h2E, prg_end[15:8]);
	push_exp(32'h2F, prg_end[7:0]);
	push_exp(32'h30, prg_end[15:8]);
	push_exp(32'h31, prg_end[7:0]);
	push_exp(32'h32, prg_end[15:8]);
	push_exp(32'hAC, 8'h00);
	push_exp(32'hAD, 8'h00);
	push_exp(32'hAE, prg_end[7:0]);
	push_exp(32'hAF, prg_end[15:8]);
endtask

// ========================================
// CRT file with two chip packets
// ========================================
task automatic build_crt();
	int addr;
	int size;
	logic [7:0] b;
	clear_lists();
	for (int i = 0; i < 64; i++)
		push_file(8'(rand_range(0, 255)), 1'b0);
	exp_cart_id = 16'(rand_range(0, 65535));
	exp_exrom = 8'(rand_range(0, 1));
	exp_game = 8'(rand_range(0, 1));
	file_buf[32'h16] = exp_cart_id[15:8];
	file_buf[32'h17] = exp_cart_id[7:0];
	file_buf[32'h18] = exp_exrom;
	file_buf[32'h19] = exp_game;
	addr = 32'h0010_0000;
	for (int p = 0; p < 2; p++) begin
		size = rand_range(10, 60);
		// Packet data starts on the next 8 KB boundary
		addr = (addr + 8191) & 32'hFFFF_E000;
		exp_bank_type[p] = 8'(rand_range(0, 2));
		exp_bank_num[p] = 16'(p);
		exp_bank_laddr[p] = 16'(rand_range(0, 65535));
		exp_bank_size[p] = 16'(size);
		push_file(8'h43, 1'b0);
		push_file(8'h48, 1'b0);
		push_file(8'h49, 1'b0);
		push_file(8'h50, 1'b0);
		push_file(8'h00, 1'b0);
		push_file(8'h00, 1'b0);
		push_file(8'((size + 16) >> 8), 1'b0);
		push_file(8'(size + 16), 1'b0);
		push_file(8'h00, 1'b0);
		push_file(exp_bank_type[p], 1'b0);
		push_file(exp_bank_num[p][15:8], 1'b0);
		push_file(exp_bank_num[p][7:0], 1'b0);
		push_file(exp_bank_laddr[p][15:8], 1'b0);
		push_file(exp_bank_laddr[p][7:0], 1'b0);
		push_file(exp_bank_size[p][15:8], 1'b0);
		push_file(exp_bank_size[p][7:0], 1'b0);
		for (int i = 0; i < size; i++) begin
			b = 8'(rand_range(0, 255));
			push_file(b, 1'b1);
			push_exp(addr + i, b);
		end
		addr = addr + size;
	end
endtask

`endif

// ==== tb/tb_c64_loader.sv ====
// Testbench for the loader top level. Erases RAM, loads a random PRG file
// and a two packet CRT file under random memory windows, and compares every
// memory write with the list built from the loader rules.
`timescale 1ns/10ps
`default_nettype none

module tb_c64_loader;

	// Allows twice the nominal run of 40 clocks per erased byte plus the files
	localparam int TIMEOUT = 2 * (65536 * 40 + 400 * 40);

	logic              clk_sys;
	logic              RESET;
	logic              ioctl_download_i;
	logic [7:0]        ioctl_index_i;
	logic              ioctl_wr_i;
	loader_pkg::addr_t ioctl_addr_i;
	logic [7:0]        ioctl_data_i;
	logic              io_cycle_i;
	logic              erase_start_i;
	wire               ioctl_wait_o, mem_ce_o, mem_we_o;
	wire [24:0]        mem_addr_o;
	wire [7:0]         mem_data_o, cart_exrom_o, cart_game_o, bank_type_o;
	wire [15:0]        cart_id_o, bank_num_o, bank_laddr_o, bank_size_o;
	wire               bank_wr_o, cart_attached_o, inject_done_o, erase_busy_o;

	integer seed = 32'h9d68_06db;
	int     errors = 0;
	int     cycles = 0;
	int     inj_count = 0;
	int     bank_count = 0;
	logic   we_prev = 1'b0;

	`include "tb_loader_model.svh"

	c64_loader_top dut0 (
		.clk_sys(clk_sys), .RESET(RESET), .ioctl_download_i(ioctl_download_i),
		.ioctl_index_i(ioctl_index_i), .ioctl_wr_i(ioctl_wr_i),
		.ioctl_addr_i(ioctl_addr_i), .ioctl_data_i(ioctl_data_i),
		.io_cycle_i(io_cycle_i), .erase_start_i(erase_start_i),
		.ioctl_wait_o(ioctl_wait_o), .mem_ce_o(mem_ce_o), .mem_we_o(mem_we_o),
		.mem_addr_o(mem_addr_o), .mem_data_o(mem_data_o), .cart_id_o(cart_id_o),
		.cart_exrom_o(cart_exrom_o), .cart_game_o(cart_game_o),
		.bank_type_o(bank_type_o), .bank_num_o(bank_num_o),
		.bank_laddr_o(bank_laddr_o), .bank_size_o(bank_size_o),
		.bank_wr_o(bank_wr_o), .cart_attached_o(cart_attached_o),
		.inject_done_o(inject_done_o), .erase_busy_o(erase_busy_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s got %h expected %h", name, got, exp);
		end
	endtask

	// Memory windows stay high at least two clocks so that every write ends
	initial begin
		io_cycle_i = 1'b0;
		forever begin
			repeat (rand_range(1, 20)) @(negedge clk_sys);
			io_cycle_i = 1'b1;
			repeat (rand_range(2, 20)) @(negedge clk_sys);
			io_cycle_i = 1'b0;
		end
	end

	// ========================================
	// Write monitor and protocol checks
	// ========================================
	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= TIMEOUT) begin
			$display("Timeout after %0d cycles, the run did not complete", cycles);
			$display("TB FAILED");
			$finish;
		end else begin
			if (!RESET) begin
				// Chip enable and write enable rise and fall together
				check_value("mem_ce_o", 32'(mem_ce_o), 32'(mem_we_o));
				if (mem_we_o && !we_prev) begin
					if (!$onehot({dut0.crt_gnt, dut0.prg_gnt, dut0.erase_gnt})) begin
						errors++;
						$display("Memory write at %h was issued without one granted request",
							mem_addr_o);
					end
					log_addr.push_back(int'(mem_addr_o));
					log_data.push_back(mem_data_o);
					if (mem_addr_o < 25'h10000)
						ram[mem_addr_o[15:0]] <= mem_data_o;
				end
				if (inject_done_o)
					inj_count++;
				if (bank_wr_o) begin
					if (bank_count < 2) begin
						check_value("bank_type_o", 32'(bank_type_o),
							32'(exp_bank_type[bank_count]));
						check_value("bank_num_o", 32'(bank_num_o),
							32'(exp_bank_num[bank_count]));
						check_value("bank_laddr_o", 32'(bank_laddr_o),
							32'(exp_bank_laddr[bank_count]));
						check_value("bank_size_o", 32'(bank_size_o),
							32'(exp_bank_size[bank_count]));
					end
					bank_count++;
				end
			end
			we_prev <= mem_we_o;
		end
	end

	task automatic send_byte(int offset, logic [7:0] data, bit makes_write);
		while (ioctl_wait_o)
			@(negedge clk_sys);
		ioctl_addr_i = loader_pkg::addr_t'(offset);
		ioctl_data_i = data;
		ioctl_wr_i = 1'b1;
		@(negedge clk_sys);
		ioctl_wr_i = 1'b0;
		// A byte that becomes a write holds the host back until it is granted
		check_value("ioctl_wait_o", 32'(ioctl_wait_o), 32'(makes_write));
	endtask

	task automatic send_file(logic [7:0] idx);
		@(negedge clk_sys);
		ioctl_index_i = idx;
		@(negedge clk_sys);
		ioctl_download_i = 1'b1;
		@(negedge clk_sys);
		for (int i = 0; i < file_buf.size(); i++)
			send_byte(i, file_buf[i], file_wr[i]);
		ioctl_download_i = 1'b0;
	endtask

	task automatic compare_log(string phase);
		int n;
		if (log_addr.size() != exp_addr.size()) begin
			errors++;
			$display("%s phase wrote %0d bytes where %0d were expected", phase,
				log_addr.size(), exp_addr.size());
		end
		n = (log_addr.size() < exp_addr.size()) ? log_addr.size() : exp_addr.size();
		for (int i = 0; i < n; i++) begin
			check_value({phase, " mem_addr_o"}, 32'(log_addr[i]), 32'(exp_addr[i]));
			check_value({phase, " mem_data_o"}, 32'(log_data[i]), 32'(exp_data[i]));
		end
		log_addr.delete();
		log_data.delete();
	endtask

	initial begin
		RESET = 1'b1;
		ioctl_download_i = 1'b0;
		ioctl_index_i = 8'h00;
		ioctl_wr_i = 1'b0;
		ioctl_addr_i = '0;
		ioctl_data_i = 8'h00;
		erase_start_i = 1'b0;
		repeat (16) @(negedge clk_sys);
		RESET = 1'b0;

		// ========================================
		// RAM erase
		// ========================================
		expect_erase();
		@(negedge clk_sys);
		erase_start_i = 1'b1;
		@(negedge clk_sys);
		erase_start_i = 1'b0;
		while (erase_busy_o)
			@(negedge clk_sys);
		repeat (4) @(negedge clk_sys);
		compare_log("erase");

		// PRG download followed by the zero page pointers
		build_prg();
		send_file(loader_pkg::IDX_PRG);
		while (inj_count == 0)
			@(negedge clk_sys);
		repeat (8) @(negedge clk_sys);
		compare_log("prg");
		check_value("inject_done_o pulses", 32'(inj_count), 32'd1);
		for (int a = 0; a < 256; a++) begin
			if (!((a >= 32'h2B && a <= 32'h32) || (a >= 32'hAC && a <= 32'hAF)))
				check_value("zero page byte", 32'(ram[a]), 32'(stripe_byte(a)));
		end

		// ========================================
		// CRT download
		// ========================================
		build_crt();
		send_file(loader_pkg::IDX_CRT);
		while (ioctl_wait_o)
			@(negedge clk_sys);
		repeat (8) @(negedge clk_sys);
		compare_log("crt");
		check_value("bank_wr_o pulses", 32'(bank_count), 32'd2);
		check_value("cart_id_o", 32'(cart_id_o), 32'(exp_cart_id));
		check_value("cart_exrom_o", 32'(cart_exrom_o), 32'(exp_exrom));
		check_value("cart_game_o", 32'(cart_game_o), 32'(exp_game));
		check_value("cart_attached_o", 32'(cart_attached_o), 32'd1);

		$display("Run complete after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
